//--- rtl/dcache_pkg.sv
package dcache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_WAYS     = 2;
    localparam int LINE_BYTES   = 16;
    localparam int OFFSET_BITS  = 4;
    // One enable per byte per way, way 1 in the upper half
    localparam int BANK_WE_BITS = NUM_WAYS * LINE_BYTES;

    typedef logic [31:0]             addr_t;
    typedef logic [NUM_WAYS-1:0]     way_hit_t;
    typedef logic [BANK_WE_BITS-1:0] bank_we_t;
    typedef logic [NUM_WAYS-1:0]     tag_we_t;

    ////////////////////////////////////////////////////////////////////////////
    // Requests and array commands
    ////////////////////////////////////////////////////////////////////////////

    // Store codes match the pipeline's mem_type field
    typedef enum logic [2:0] {
        OP_LOAD = 3'b000,
        OP_ST_W = 3'b001,
        OP_ST_B = 3'b110,
        OP_ST_H = 3'b111
    } mem_op_t;

    typedef struct packed {
        addr_t   addr;
        mem_op_t op;
    } cache_req_t;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_STORE_HIT,
        CMD_LOAD_HIT,
        CMD_REFILL
    } cmd_kind_t;

    typedef struct packed {
        cmd_kind_t  kind;
        logic       way;
        cache_req_t req;
    } array_cmd_t;

    // One-cycle write to data banks, tag/valid and LRU
    typedef struct packed {
        bank_we_t data_we;
        tag_we_t  tag_we;
        logic     lru_update;
        logic     lru_way;
    } array_wr_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS_ADDR,
        S_MISS_DATA,
        S_REFILL,
        S_WAIT_WRITE
    } ctrl_state_t;

endpackage

//--- rtl/dcache_req_stage.sv
module dcache_req_stage (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    input  dcache_pkg::cache_req_t  req,
    input  logic                    retire,
    input  dcache_pkg::way_hit_t    hit,
    input  logic                    in_lookup,
    output logic                    req_ready,
    output dcache_pkg::cache_req_t  cur_req,
    output logic                    cur_valid
);

    logic take;
    logic leave_on_hit;

    // Current request hits this cycle, so its slot frees up
    assign leave_on_hit = in_lookup && (hit != '0);

    assign req_ready = !cur_valid || leave_on_hit;
    assign take      = req_valid && req_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Holding register
    ////////////////////////////////////////////////////////////////////////////

    // A missed request stays here until the replay hits
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cur_valid <= 1'b0;
        end else if (take) begin
            cur_valid <= 1'b1;
        end else if (retire) begin
            cur_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cur_req <= req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Requester honours req_ready
    a_req_needs_ready: assert property (
        @(posedge clk) disable iff (!rstn)
        req_valid |-> req_ready
    );

endmodule

//--- rtl/dcache_ctrl_fsm.sv
module dcache_ctrl_fsm (
    input  logic                    clk,
    input  logic                    rstn,
    input  dcache_pkg::cache_req_t  cur_req,
    input  logic                    cur_valid,
    input  dcache_pkg::way_hit_t    hit,
    input  logic                    ar_ready,
    input  logic                    r_valid,
    input  logic                    r_last,
    input  logic                    way_sel,
    input  logic                    write_finish,
    output logic                    retire,
    output logic                    in_lookup,
    output logic                    ar_valid,
    output dcache_pkg::addr_t       ar_addr,
    output logic                    r_ready,
    output dcache_pkg::array_cmd_t  cmd
);

    import dcache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    addr_t       line_addr;
    logic        is_hit;
    logic        is_store;
    logic        last_beat;

    // Idle picks up a fresh request directly, lookup also covers replay
    assign in_lookup = cur_valid && ((state == S_IDLE) || (state == S_LOOKUP));
    assign is_hit    = (hit != '0);
    assign retire    = in_lookup && is_hit;
    assign is_store  = (cur_req.op != OP_LOAD);
    assign last_beat = r_valid && r_last;

    ////////////////////////////////////////////////////////////////////////////
    // State register and next state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE, S_LOOKUP: begin
                if (!cur_valid) begin
                    state_nxt = S_IDLE;
                end else if (is_hit) begin
                    // Next request may already be in the stage
                    state_nxt = S_LOOKUP;
                end else begin
                    state_nxt = S_MISS_ADDR;
                end
            end
            S_MISS_ADDR: begin
                if (ar_ready) begin
                    state_nxt = S_MISS_DATA;
                end
            end
            S_MISS_DATA: begin
                if (last_beat) begin
                    state_nxt = S_REFILL;
                end
            end
            S_REFILL: begin
                state_nxt = S_WAIT_WRITE;
            end
            S_WAIT_WRITE: begin
                // Victim written back, replay the held request
                if (write_finish) begin
                    state_nxt = S_LOOKUP;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (in_lookup && !is_hit) begin
            line_addr <= {cur_req.addr[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
    end

    assign ar_valid = (state == S_MISS_ADDR);
    assign ar_addr  = line_addr;
    assign r_ready  = (state == S_MISS_DATA);

    // Order to the array write stage
    always_comb begin
        cmd.kind = CMD_NONE;
        cmd.way  = 1'b0;
        cmd.req  = cur_req;
        if (retire) begin
            cmd.kind = is_store ? CMD_STORE_HIT : CMD_LOAD_HIT;
            cmd.way  = hit[1];
        end else if (state == S_REFILL) begin
            cmd.kind = CMD_REFILL;
            cmd.way  = way_sel;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Tag compare never reports both ways
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        in_lookup |-> $onehot0(hit)
    );

    // Address held until the memory side takes it
    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr))
    );

endmodule

//--- rtl/dcache_array_wr.sv
module dcache_array_wr (
    input  logic                    clk,
    input  logic                    rstn,
    input  dcache_pkg::array_cmd_t  cmd,
    output dcache_pkg::array_wr_t   wr,
    output logic                    resp_valid,
    output logic                    resp_store
);

    import dcache_pkg::*;

    logic [OFFSET_BITS-1:0] offset;
    logic [LINE_BYTES-1:0]  byte_we;
    logic [LINE_BYTES-1:0]  line_we;
    bank_we_t               bank_we;
    array_wr_t              wr_nxt;
    logic                   resp_nxt;

    assign offset = cmd.req.addr[OFFSET_BITS-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Store byte mask within one line
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        byte_we = '0;
        case (cmd.req.op)
            OP_ST_W: begin
                byte_we = LINE_BYTES'(4'hf) << {offset[3:2], 2'b00};
            end
            OP_ST_B: begin
                byte_we = LINE_BYTES'(1'b1) << offset;
            end
            OP_ST_H: begin
                // Odd half-word address writes nothing
                if (!offset[0]) begin
                    byte_we = LINE_BYTES'(2'b11) << offset;
                end
            end
            default: begin
                byte_we = '0;
            end
        endcase
    end

    // Refill takes the whole line
    assign line_we = (cmd.kind == CMD_REFILL) ? {LINE_BYTES{1'b1}} : byte_we;
    assign bank_we = cmd.way ? {line_we, {LINE_BYTES{1'b0}}}
                             : {{LINE_BYTES{1'b0}}, line_we};

    always_comb begin
        wr_nxt   = '0;
        resp_nxt = 1'b0;
        if (cmd.kind == CMD_STORE_HIT || cmd.kind == CMD_REFILL) begin
            wr_nxt.data_we = bank_we;
            wr_nxt.tag_we  = tag_we_t'(1) << cmd.way;
        end
        if (cmd.kind != CMD_NONE) begin
            wr_nxt.lru_update = 1'b1;
            wr_nxt.lru_way    = cmd.way;
        end
        if (cmd.kind == CMD_STORE_HIT || cmd.kind == CMD_LOAD_HIT) begin
            resp_nxt = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr         <= '0;
            resp_valid <= 1'b0;
            resp_store <= 1'b0;
        end else begin
            wr         <= wr_nxt;
            resp_valid <= resp_nxt;
            resp_store <= (cmd.kind == CMD_STORE_HIT);
        end
    end

endmodule

//--- rtl/dcache_ctrl.sv
module dcache_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    input  dcache_pkg::cache_req_t  req,
    output logic                    req_ready,
    input  dcache_pkg::way_hit_t    hit,
    output logic                    ar_valid,
    output dcache_pkg::addr_t       ar_addr,
    input  logic                    ar_ready,
    input  logic                    r_valid,
    input  logic                    r_last,
    output logic                    r_ready,
    input  logic                    way_sel,
    input  logic                    write_finish,
    output dcache_pkg::array_wr_t   wr,
    output logic                    resp_valid,
    output logic                    resp_store
);

    import dcache_pkg::*;

    cache_req_t cur_req;
    logic       cur_valid;
    logic       retire;
    logic       in_lookup;
    array_cmd_t cmd;

    // Request capture and hold for replay
    dcache_req_stage u_req_stage (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req       (req),
        .retire    (retire),
        .hit       (hit),
        .in_lookup (in_lookup),
        .req_ready (req_ready),
        .cur_req   (cur_req),
        .cur_valid (cur_valid)
    );

    dcache_ctrl_fsm u_ctrl_fsm (
        .clk          (clk),
        .rstn         (rstn),
        .cur_req      (cur_req),
        .cur_valid    (cur_valid),
        .hit          (hit),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r_last       (r_last),
        .way_sel      (way_sel),
        .write_finish (write_finish),
        .retire       (retire),
        .in_lookup    (in_lookup),
        .ar_valid     (ar_valid),
        .ar_addr      (ar_addr),
        .r_ready      (r_ready),
        .cmd          (cmd)
    );

    dcache_array_wr u_array_wr (
        .clk        (clk),
        .rstn       (rstn),
        .cmd        (cmd),
        .wr         (wr),
        .resp_valid (resp_valid),
        .resp_store (resp_store)
    );

endmodule

//--- testbench/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk  = 1'b0;
        rstn = 1'b0;
        // Two full periods in reset, released on a falling edge
        repeat (2) @(negedge clk);
        rstn = 1'b1;
    end

    always #5 clk = ~clk;

endmodule

//--- testbench/dcache_ctrl_tb.sv
module dcache_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    typedef struct packed {
        array_wr_t wr;
        logic      resp_valid;
        logic      resp_store;
    } outputs_t;

    logic       clk;
    logic       rstn;
    logic       req_valid;
    cache_req_t req;
    logic       req_ready;
    way_hit_t   hit;
    logic       ar_valid;
    addr_t      ar_addr;
    logic       ar_ready;
    logic       r_valid;
    logic       r_last;
    logic       r_ready;
    logic       way_sel;
    logic       write_finish;
    array_wr_t  wr;
    logic       resp_valid;
    logic       resp_store;

    int         cyc = 0;
    int         value_errs = 0;
    int         proto_errs = 0;
    outputs_t   exp_tab [int];
    cache_req_t pend_req [$];
    logic       pend_way [$];
    logic       ar_expected = 1'b0;
    addr_t      exp_ar_addr = '0;

    tb_clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    dcache_ctrl u_dcache_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .hit          (hit),
        .ar_valid     (ar_valid),
        .ar_addr      (ar_addr),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r_last       (r_last),
        .r_ready      (r_ready),
        .way_sel      (way_sel),
        .write_finish (write_finish),
        .wr           (wr),
        .resp_valid   (resp_valid),
        .resp_store   (resp_store)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic array_wr_t expected_wr(input cmd_kind_t kind, input logic way,
                                              input mem_op_t op, input addr_t addr);
        array_wr_t             exp_w;
        logic [LINE_BYTES-1:0] bytes;
        int                    off;
        int                    base;
        int                    b;
        exp_w = '0;
        bytes = '0;
        off   = int'(addr[OFFSET_BITS-1:0]);
        base  = way ? LINE_BYTES : 0;
        for (b = 0; b < LINE_BYTES; b++) begin
            case (op)
                OP_ST_W: bytes[b] = (b / 4 == off / 4);
                OP_ST_B: bytes[b] = (b == off);
                // Odd address gives no bytes at all
                OP_ST_H: bytes[b] = (off % 2 == 0) && (b / 2 == off / 2);
                default: bytes[b] = 1'b0;
            endcase
        end
        if (kind == CMD_REFILL) begin
            bytes = '1;
        end
        if (kind == CMD_STORE_HIT || kind == CMD_REFILL) begin
            for (b = 0; b < LINE_BYTES; b++) begin
                exp_w.data_we[base + b] = bytes[b];
            end
            exp_w.tag_we[way] = 1'b1;
        end
        if (kind != CMD_NONE) begin
            exp_w.lru_update = 1'b1;
            exp_w.lru_way    = way;
        end
        return exp_w;
    endfunction

    function automatic outputs_t expected_out(input cmd_kind_t kind, input logic way,
                                              input cache_req_t r);
        outputs_t o;
        o.wr         = expected_wr(kind, way, r.op, r.addr);
        o.resp_valid = (kind == CMD_LOAD_HIT) || (kind == CMD_STORE_HIT);
        o.resp_store = (kind == CMD_STORE_HIT);
        return o;
    endfunction

    function automatic way_hit_t onehot(input logic way);
        return way ? 2'b10 : 2'b01;
    endfunction

    // mode 0 loads only, 1 stores only, 2 anything
    function automatic mem_op_t pick_op(input int mode);
        int sel;
        sel = 0;
        if (mode != 0) begin
            sel = $urandom_range((mode == 1) ? 1 : 0, 3);
        end
        case (sel)
            0:       return OP_LOAD;
            1:       return OP_ST_W;
            2:       return OP_ST_B;
            default: return OP_ST_H;
        endcase
    endfunction

    function automatic cache_req_t make_req(input addr_t a, input mem_op_t op);
        cache_req_t r;
        r.addr = a;
        r.op   = op;
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        value_errs++;
        $display("Fail t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    endtask

    task automatic report_protocol(input string what);
        proto_errs++;
        $display("Error t=%0t %s", $time, what);
    endtask

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        report_protocol({"timeout waiting for ", what});
        finish_run();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic queue_hit(input cache_req_t r, input logic way);
        pend_req.push_back(r);
        pend_way.push_back(way);
    endtask

    // Strobe every queued request on consecutive cycles with a hit in its lookup
    task automatic send_burst();
        int         n;
        int         i;
        cache_req_t r;
        n = pend_req.size();
        for (i = 0; i <= n; i++) begin
            @(negedge clk);
            if (i == 0 && !req_ready) begin
                report_protocol("req_ready low with the stage empty");
            end
            if (i < n) begin
                req_valid = 1'b1;
                req       = pend_req[i];
            end else begin
                req_valid = 1'b0;
            end
            if (i > 0) begin
                r   = pend_req[i-1];
                hit = onehot(pend_way[i-1]);
                exp_tab[cyc + 1] = expected_out((r.op == OP_LOAD) ? CMD_LOAD_HIT
                                                                  : CMD_STORE_HIT,
                                                pend_way[i-1], r);
            end
        end
        @(negedge clk);
        hit = '0;
        pend_req.delete();
        pend_way.delete();
    endtask

    task automatic run_miss(input cache_req_t r, input logic victim);
        int   guard;
        int   gap;
        logic seen;
        @(negedge clk);
        way_sel   = victim;
        req_valid = 1'b1;
        req       = r;
        @(negedge clk);
        req_valid   = 1'b0;
        hit         = '0;
        exp_ar_addr = r.addr & ~addr_t'(LINE_BYTES - 1);
        ar_expected = 1'b1;
        seen  = 1'b0;
        guard = 0;
        while (!seen) begin
            @(negedge clk);
            if (req_ready) begin
                report_protocol("req_ready high while a miss holds the stage");
            end
            if (wr.lru_update) begin
                seen = 1'b1;
            end else begin
                guard++;
                if (guard > 100) begin
                    stop_on_timeout("refill write");
                end
            end
        end
        ar_expected = 1'b0;
        // Victim writeback still busy so nothing may answer yet
        gap = $urandom_range(0, 5);
        repeat (gap) @(negedge clk);
        @(negedge clk);
        write_finish = 1'b1;
        @(negedge clk);
        write_finish = 1'b0;
        hit          = onehot(victim);
        exp_tab[cyc + 1] = expected_out((r.op == OP_LOAD) ? CMD_LOAD_HIT : CMD_STORE_HIT,
                                        victim, r);
        @(negedge clk);
        hit = '0;
    endtask

    task automatic check_reset();
        int guard;
        guard = 0;
        @(posedge clk);
        do begin
            @(posedge clk);
            if (ar_valid || r_ready || resp_valid || resp_store || wr != '0) begin
                report_protocol("outputs active in or right after reset");
            end
            if (!req_ready) begin
                report_protocol("req_ready low in or right after reset");
            end
            guard++;
            if (guard > 20) begin
                stop_on_timeout("reset release");
            end
        end while (!rstn);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory side
    ////////////////////////////////////////////////////////////////////////////

    initial begin : mem_responder
        int         phase;
        int         delay;
        int         beats;
        cache_req_t no_req;
        phase    = 0;
        delay    = 0;
        beats    = 0;
        no_req   = '0;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_last   = 1'b0;
        forever begin
            @(negedge clk);
            ar_ready = 1'b0;
            r_valid  = 1'b0;
            r_last   = 1'b0;
            if (phase == 2) begin
                if (ar_valid) begin
                    report_protocol("ar_valid still high after the address handshake");
                end
                if (!r_ready) begin
                    report_protocol("r_ready low before the last beat");
                end
                if (delay == 0) begin
                    r_valid = 1'b1;
                    r_last  = (beats == 3);
                    if (beats == 3) begin
                        // Refill cycle follows the last beat
                        exp_tab[cyc + 2] = expected_out(CMD_REFILL, way_sel, no_req);
                        phase = 0;
                    end
                    beats++;
                    delay = $urandom_range(0, 2);
                end else begin
                    delay--;
                end
            end else begin
                if (phase == 0) begin
                    if (r_ready) begin
                        report_protocol("r_ready high outside a burst");
                    end
                    if (ar_valid) begin
                        delay = $urandom_range(0, 3);
                        phase = 1;
                    end
                end
                if (phase == 1) begin
                    if (!ar_valid) begin
                        report_protocol("ar_valid dropped before ar_ready");
                    end
                    if (delay == 0) begin
                        ar_ready = 1'b1;
                        phase    = 2;
                        beats    = 0;
                        delay    = $urandom_range(0, 2);
                    end else begin
                        delay--;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////////////////////////////

    initial begin : compare_outputs
        outputs_t exp_o;
        forever begin
            @(negedge clk);
            exp_o = '0;
            if (exp_tab.exists(cyc)) begin
                exp_o = exp_tab[cyc];
                exp_tab.delete(cyc);
            end
            if (wr.data_we !== exp_o.wr.data_we) begin
                report_mismatch("wr.data_we", 64'(wr.data_we), 64'(exp_o.wr.data_we));
            end
            if (wr.tag_we !== exp_o.wr.tag_we) begin
                report_mismatch("wr.tag_we", 64'(wr.tag_we), 64'(exp_o.wr.tag_we));
            end
            if (wr.lru_update !== exp_o.wr.lru_update) begin
                report_mismatch("wr.lru_update", 64'(wr.lru_update), 64'(exp_o.wr.lru_update));
            end
            if (wr.lru_way !== exp_o.wr.lru_way) begin
                report_mismatch("wr.lru_way", 64'(wr.lru_way), 64'(exp_o.wr.lru_way));
            end
            if (resp_valid !== exp_o.resp_valid) begin
                report_mismatch("resp_valid", 64'(resp_valid), 64'(exp_o.resp_valid));
            end
            if (resp_store !== exp_o.resp_store) begin
                report_mismatch("resp_store", 64'(resp_store), 64'(exp_o.resp_store));
            end
            if (ar_valid && !ar_expected) begin
                report_protocol("ar_valid high with no miss outstanding");
            end
            if (ar_valid && ar_expected && ar_addr !== exp_ar_addr) begin
                report_mismatch("ar_addr", 64'(ar_addr), 64'(exp_ar_addr));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int         i;
        cache_req_t r;
        void'($urandom(86));
        req_valid    = 1'b0;
        req          = '0;
        hit          = '0;
        way_sel      = 1'b0;
        write_finish = 1'b0;

        check_reset();

        // Load hits in alternating ways
        for (i = 0; i < 6; i++) begin
            queue_hit(make_req(addr_t'($urandom), OP_LOAD), 1'(i % 2));
            send_burst();
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end

        // Store masks at directed corners and random offsets
        queue_hit(make_req(32'h0000_1005, OP_ST_H), 1'b1);
        queue_hit(make_req(32'h0000_1006, OP_ST_H), 1'b0);
        queue_hit(make_req(32'h0000_100f, OP_ST_B), 1'b1);
        queue_hit(make_req(32'h0000_1009, OP_ST_W), 1'b0);
        send_burst();
        for (i = 0; i < 12; i++) begin
            queue_hit(make_req(addr_t'($urandom), pick_op(1)), 1'($urandom_range(0, 1)));
            send_burst();
        end

        // Back-to-back mixed hits
        repeat (2) begin
            for (i = 0; i < 10; i++) begin
                queue_hit(make_req(addr_t'($urandom), pick_op(2)), 1'($urandom_range(0, 1)));
            end
            send_burst();
        end

        // Misses with refill, writeback wait and replay
        run_miss(make_req(32'h0000_203b, OP_ST_B), 1'b1);
        for (i = 0; i < 4; i++) begin
            r = make_req(addr_t'($urandom), pick_op(2));
            run_miss(r, 1'($urandom_range(0, 1)));
        end

        // Hits still flow after a miss
        for (i = 0; i < 4; i++) begin
            queue_hit(make_req(addr_t'($urandom), pick_op(2)), 1'($urandom_range(0, 1)));
        end
        send_burst();

        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

//--- build.f
rtl/dcache_pkg.sv
rtl/dcache_req_stage.sv
rtl/dcache_ctrl_fsm.sv
rtl/dcache_array_wr.sv
rtl/dcache_ctrl.sv
testbench/tb_clk_gen.sv
testbench/dcache_ctrl_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module dcache_ctrl_tb -Mdir obj_dir -f build.f
	./obj_dir/Vdcache_ctrl_tb | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
